// ==== design/ldq_state_pkg.sv ====
`default_nettype none

package ldq_state_pkg;

	localparam int LDQ_DEPTH = 8;
	localparam int LDQ_TAG_W = $clog2(LDQ_DEPTH);
	localparam int XLEN      = 32;
	localparam int PRF_W     = 6;
	localparam int ROB_W     = 6;

	// life of one queue entry
	typedef enum logic [2:0] {
		LDQ_FREE,
		LDQ_WAIT_ADDR,
		LDQ_READY,     // address known, not yet sent to the cache
		LDQ_ISSUED,
		LDQ_HAS_DATA,
		LDQ_DONE       // written back, waits for retire
	} ldq_state_e;

	typedef struct packed {
		logic [XLEN-1:0]  addr;
		logic [2:0]       size;
		logic [XLEN-1:0]  pc;
		logic [PRF_W-1:0] dest_prn;
		logic [ROB_W-1:0] rob_tag;
		logic [XLEN-1:0]  data;
	} ldq_payload_t;

	// lowest set bit wins, 0 for an empty mask
	function automatic logic [LDQ_TAG_W-1:0] lowest_index(input logic [LDQ_DEPTH-1:0] mask);
		logic [LDQ_TAG_W-1:0] idx;
		idx = '0;
		for (int i = LDQ_DEPTH - 1; i >= 0; i--) begin
			if (mask[i]) begin
				idx = LDQ_TAG_W'(i);
			end
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

// ==== design/lsu_if_pkg.sv ====
`default_nettype none

package lsu_if_pkg;

	typedef logic [ldq_state_pkg::LDQ_TAG_W-1:0] ldq_tag_t;

	typedef struct packed {
		ldq_tag_t tag;
	} dispatch_resp_t;

	// address phase from the execute stage
	typedef struct packed {
		logic                            valid;
		ldq_tag_t                        tag;
		logic [ldq_state_pkg::XLEN-1:0]  addr;
		logic [2:0]                      size;
		logic [ldq_state_pkg::XLEN-1:0]  pc;
		logic [ldq_state_pkg::PRF_W-1:0] prn;
		logic [ldq_state_pkg::ROB_W-1:0] rob_tag;
	} execute_ld_t;

	typedef struct packed {
		logic [ldq_state_pkg::XLEN-1:0] addr;
		logic [2:0]                     size;
		ldq_tag_t                       tag;
	} issue_req_t;

	// cache returns data by queue tag
	typedef struct packed {
		logic                           valid;
		ldq_tag_t                       tag;
		logic [ldq_state_pkg::XLEN-1:0] data;
	} dcache_resp_t;

	typedef struct packed {
		logic [ldq_state_pkg::XLEN-1:0]  data;
		logic [ldq_state_pkg::XLEN-1:0]  pc;
		logic [ldq_state_pkg::PRF_W-1:0] dest_prn;
		logic [ldq_state_pkg::ROB_W-1:0] rob_tag;
	} writeback_t;

	typedef struct packed {
		logic     valid;
		ldq_tag_t tag;
	} retire_slot_t;

endpackage

`default_nettype wire

// ==== design/ldq_alloc.sv ====
`default_nettype none

module ldq_alloc #(
	parameter int DISPATCH_WIDTH = 4
) (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 pipe_flush,
	input  wire  [DISPATCH_WIDTH-1:0]           dispatch_valid,
	input  wire  lsu_if_pkg::retire_slot_t      retire [DISPATCH_WIDTH],
	output logic                                dispatch_ready,
	output lsu_if_pkg::dispatch_resp_t          dispatch_resp [DISPATCH_WIDTH],
	output logic [ldq_state_pkg::LDQ_DEPTH-1:0] alloc_strobe,
	output logic [ldq_state_pkg::LDQ_DEPTH-1:0] retire_strobe
);

	import ldq_state_pkg::*;

	// msb of each pointer is the wrap bit
	logic [LDQ_TAG_W:0] head_ptr;
	logic [LDQ_TAG_W:0] tail_ptr;
	logic [LDQ_TAG_W:0] occupancy;
	logic [LDQ_TAG_W:0] disp_cnt;
	logic [LDQ_TAG_W:0] ret_cnt;
	logic [LDQ_TAG_W:0] slot_ptr;

	assign occupancy      = tail_ptr - head_ptr;
	assign dispatch_ready = int'(occupancy) + DISPATCH_WIDTH <= LDQ_DEPTH; // room for a full group

	// valid slots take consecutive tags from tail, holes read 0
	always_comb begin
		disp_cnt     = '0;
		slot_ptr     = tail_ptr;
		alloc_strobe = '0;
		for (int s = 0; s < DISPATCH_WIDTH; s++) begin
			slot_ptr         = tail_ptr + disp_cnt;
			dispatch_resp[s] = '0;
			if (dispatch_valid[s]) begin
				dispatch_resp[s].tag                  = slot_ptr[LDQ_TAG_W-1:0];
				alloc_strobe[slot_ptr[LDQ_TAG_W-1:0]] = 1'b1;
				disp_cnt                              = disp_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		ret_cnt       = '0;
		retire_strobe = '0;
		for (int s = 0; s < DISPATCH_WIDTH; s++) begin
			if (retire[s].valid) begin
				retire_strobe[retire[s].tag] = 1'b1;
				ret_cnt                      = ret_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_ptr <= '0;
			tail_ptr <= '0;
		end else if (pipe_flush) begin
			head_ptr <= '0; // tags restart at 0
			tail_ptr <= '0;
		end else begin
			head_ptr <= head_ptr + ret_cnt;
			tail_ptr <= tail_ptr + disp_cnt;
		end
	end

	// the commit side never retires more loads than are in flight
	assert property (@(posedge clk) disable iff (!rst_n) ret_cnt <= occupancy)
		else $error("ldq_alloc: %0d retires with %0d loads in queue", ret_cnt, occupancy);

endmodule

`default_nettype wire

// ==== design/ldq_entry_array.sv ====
`default_nettype none

module ldq_entry_array (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 pipe_flush,
	input  wire  [ldq_state_pkg::LDQ_DEPTH-1:0] alloc_strobe,
	input  wire  [ldq_state_pkg::LDQ_DEPTH-1:0] retire_strobe,
	input  wire  lsu_if_pkg::execute_ld_t       execute_ld,
	input  wire                                 issue_accept,
	input  wire  lsu_if_pkg::ldq_tag_t          issue_tag,
	input  wire  lsu_if_pkg::dcache_resp_t      dcache_resp,
	input  wire                                 wb_accept,
	input  wire  lsu_if_pkg::ldq_tag_t          wb_tag,
	output logic [ldq_state_pkg::LDQ_DEPTH-1:0] ready_mask,
	output logic [ldq_state_pkg::LDQ_DEPTH-1:0] data_mask,
	output ldq_state_pkg::ldq_payload_t         payload [ldq_state_pkg::LDQ_DEPTH]
);

	import ldq_state_pkg::*;
	import lsu_if_pkg::*;

	ldq_state_e           state [LDQ_DEPTH];
	logic [LDQ_DEPTH-1:0] exec_hit;
	logic [LDQ_DEPTH-1:0] issue_hit;
	logic [LDQ_DEPTH-1:0] resp_hit;
	logic [LDQ_DEPTH-1:0] wb_hit;

	for (genvar e = 0; e < LDQ_DEPTH; e++) begin : g_entry
		localparam ldq_tag_t ENTRY_TAG = ldq_tag_t'(e);

		assign exec_hit[e]  = execute_ld.valid && execute_ld.tag == ENTRY_TAG;
		assign issue_hit[e] = issue_accept && issue_tag == ENTRY_TAG;
		assign resp_hit[e]  = dcache_resp.valid && dcache_resp.tag == ENTRY_TAG;
		assign wb_hit[e]    = wb_accept && wb_tag == ENTRY_TAG;

		assign ready_mask[e] = state[e] == LDQ_READY;
		assign data_mask[e]  = state[e] == LDQ_HAS_DATA;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				state[e] <= LDQ_FREE;
			end else if (pipe_flush) begin
				state[e] <= LDQ_FREE;
			end else begin
				case (state[e])
					LDQ_FREE:      if (alloc_strobe[e]) state[e] <= LDQ_WAIT_ADDR;
					LDQ_WAIT_ADDR: if (exec_hit[e]) state[e] <= LDQ_READY;
					LDQ_READY:     if (issue_hit[e]) state[e] <= LDQ_ISSUED;
					LDQ_ISSUED:    if (resp_hit[e]) state[e] <= LDQ_HAS_DATA;
					LDQ_HAS_DATA:  if (wb_hit[e]) state[e] <= LDQ_DONE;
					LDQ_DONE:      if (retire_strobe[e]) state[e] <= LDQ_FREE;
					default:       state[e] <= LDQ_FREE;
				endcase
			end
		end

		always_ff @(posedge clk) begin
			if (exec_hit[e]) begin
				payload[e].addr     <= execute_ld.addr;
				payload[e].size     <= execute_ld.size;
				payload[e].pc       <= execute_ld.pc;
				payload[e].dest_prn <= execute_ld.prn;
				payload[e].rob_tag  <= execute_ld.rob_tag;
			end
			if (resp_hit[e]) begin
				payload[e].data <= dcache_resp.data;
			end
		end

		// execute only ever names a load that is allocated and still without address
		assert property (@(posedge clk) disable iff (!rst_n || pipe_flush)
			exec_hit[e] |-> state[e] == LDQ_WAIT_ADDR)
			else $error("ldq_entry_array: execute to entry %0d in %s", e, state[e].name());

		// the cache only answers requests it accepted earlier
		assert property (@(posedge clk) disable iff (!rst_n || pipe_flush)
			resp_hit[e] |-> state[e] == LDQ_ISSUED)
			else $error("ldq_entry_array: response to entry %0d in %s", e, state[e].name());

		assert property (@(posedge clk) disable iff (!rst_n || pipe_flush)
			retire_strobe[e] |-> state[e] == LDQ_DONE)
			else $error("ldq_entry_array: retire of entry %0d in %s", e, state[e].name());
	end

endmodule

`default_nettype wire

// ==== design/ldq_issue_select.sv ====
`default_nettype none

module ldq_issue_select (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 pipe_flush,
	input  wire  [ldq_state_pkg::LDQ_DEPTH-1:0] ready_mask,
	input  wire  ldq_state_pkg::ldq_payload_t   payload [ldq_state_pkg::LDQ_DEPTH],
	input  wire                                 issue_ready,
	output lsu_if_pkg::issue_req_t              issue_req,
	output logic                                issue_valid,
	output logic                                issue_accept,
	output lsu_if_pkg::ldq_tag_t                issue_tag
);

	import ldq_state_pkg::*;
	import lsu_if_pkg::*;

	logic [LDQ_DEPTH-1:0] candidates;
	ldq_tag_t             sel_tag;

	assign issue_accept = issue_valid && issue_ready;
	assign issue_tag    = issue_req.tag;

	// the entry leaving at this edge is not picked again
	always_comb begin
		candidates = ready_mask;
		if (issue_accept) begin
			candidates[issue_req.tag] = 1'b0;
		end
	end

	assign sel_tag = lowest_index(candidates);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue_valid <= 1'b0;
		end else if (pipe_flush) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= |candidates;
		end
	end

	always_ff @(posedge clk) begin
		issue_req.addr <= payload[sel_tag].addr;
		issue_req.size <= payload[sel_tag].size;
		issue_req.tag  <= sel_tag; // reselected every cycle under back-pressure
	end

	// a stalled request holds unless an older slot in the array became ready
	assert property (@(posedge clk) disable iff (!rst_n || pipe_flush)
		issue_valid && !issue_ready |=> issue_valid &&
			(issue_req == $past(issue_req) || issue_req.tag < $past(issue_req.tag)))
		else $error("ldq_issue_select: stalled request changed to tag %0d", issue_req.tag);

endmodule

`default_nettype wire

// ==== design/ldq_writeback_select.sv ====
`default_nettype none

module ldq_writeback_select (
	input  wire  [ldq_state_pkg::LDQ_DEPTH-1:0] data_mask,
	input  wire  ldq_state_pkg::ldq_payload_t   payload [ldq_state_pkg::LDQ_DEPTH],
	input  wire                                 writeback_ready,
	output lsu_if_pkg::writeback_t              writeback,
	output logic                                writeback_valid,
	output logic                                wb_accept,
	output lsu_if_pkg::ldq_tag_t                wb_tag
);

	import ldq_state_pkg::*;

	// lowest index holding data goes first
	assign wb_tag          = lowest_index(data_mask);
	assign writeback_valid = |data_mask;

	assign writeback = '{
		data:     payload[wb_tag].data,
		pc:       payload[wb_tag].pc,
		dest_prn: payload[wb_tag].dest_prn,
		rob_tag:  payload[wb_tag].rob_tag
	};

	assign wb_accept = writeback_valid && writeback_ready; // entry moves to done at this edge

endmodule

`default_nettype wire

// ==== design/ldq_top.sv ====
`default_nettype none

module ldq_top #(
	parameter int DISPATCH_WIDTH = 4
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           pipe_flush,
	input  wire  [DISPATCH_WIDTH-1:0]     dispatch_valid,
	output logic                          dispatch_ready,
	output lsu_if_pkg::dispatch_resp_t    dispatch_resp [DISPATCH_WIDTH],
	input  wire  lsu_if_pkg::execute_ld_t execute_ld,
	output lsu_if_pkg::issue_req_t        issue_req,
	output logic                          issue_valid,
	input  wire                           issue_ready,
	input  wire lsu_if_pkg::dcache_resp_t dcache_resp,
	output lsu_if_pkg::writeback_t        writeback,
	output logic                          writeback_valid,
	input  wire                           writeback_ready,
	input  wire lsu_if_pkg::retire_slot_t retire [DISPATCH_WIDTH]
);

	import ldq_state_pkg::*;
	import lsu_if_pkg::*;

	logic [LDQ_DEPTH-1:0] alloc_strobe;
	logic [LDQ_DEPTH-1:0] retire_strobe;
	logic [LDQ_DEPTH-1:0] ready_mask;
	logic [LDQ_DEPTH-1:0] data_mask;
	ldq_payload_t         payload [LDQ_DEPTH];
	logic                 issue_accept;
	ldq_tag_t             issue_tag;
	logic                 wb_accept;
	ldq_tag_t             wb_tag;

	ldq_alloc #(
		.DISPATCH_WIDTH(DISPATCH_WIDTH)
	) u_alloc (
		.clk            (clk),
		.rst_n          (rst_n),
		.pipe_flush     (pipe_flush),
		.dispatch_valid (dispatch_valid),
		.retire         (retire),
		.dispatch_ready (dispatch_ready),
		.dispatch_resp  (dispatch_resp),
		.alloc_strobe   (alloc_strobe),
		.retire_strobe  (retire_strobe)
	);

	ldq_entry_array u_entries (
		.clk           (clk),
		.rst_n         (rst_n),
		.pipe_flush    (pipe_flush),
		.alloc_strobe  (alloc_strobe),
		.retire_strobe (retire_strobe),
		.execute_ld    (execute_ld),
		.issue_accept  (issue_accept),
		.issue_tag     (issue_tag),
		.dcache_resp   (dcache_resp),
		.wb_accept     (wb_accept),
		.wb_tag        (wb_tag),
		.ready_mask    (ready_mask),
		.data_mask     (data_mask),
		.payload       (payload)
	);

	ldq_issue_select u_issue (
		.clk          (clk),
		.rst_n        (rst_n),
		.pipe_flush   (pipe_flush),
		.ready_mask   (ready_mask),
		.payload      (payload),
		.issue_ready  (issue_ready),
		.issue_req    (issue_req),
		.issue_valid  (issue_valid),
		.issue_accept (issue_accept),
		.issue_tag    (issue_tag)
	);

	ldq_writeback_select u_writeback (
		.data_mask       (data_mask),
		.payload         (payload),
		.writeback_ready (writeback_ready),
		.writeback       (writeback),
		.writeback_valid (writeback_valid),
		.wb_accept       (wb_accept),
		.wb_tag          (wb_tag)
	);

endmodule

`default_nettype wire

// ==== include/ldq_ref_model.svh ====
`ifndef LDQ_REF_MODEL_SVH
`define LDQ_REF_MODEL_SVH

// software copy of the queue, head and tail count loads and wrap through model_tag
typedef struct {
	ldq_state_pkg::ldq_state_e   state [ldq_state_pkg::LDQ_DEPTH];
	ldq_state_pkg::ldq_payload_t payload [ldq_state_pkg::LDQ_DEPTH];
	int unsigned                 head;
	int unsigned                 tail;
} ldq_model_t;

function automatic ldq_model_t model_reset();
	ldq_model_t m;
	for (int i = 0; i < ldq_state_pkg::LDQ_DEPTH; i++) begin
		m.state[i]   = ldq_state_pkg::LDQ_FREE;
		m.payload[i] = '0;
	end
	m.head = 0;
	m.tail = 0;
	return m;
endfunction

function automatic lsu_if_pkg::ldq_tag_t model_tag(int unsigned ptr);
	return lsu_if_pkg::ldq_tag_t'(ptr % ldq_state_pkg::LDQ_DEPTH);
endfunction

function automatic int model_free(ldq_model_t m);
	return ldq_state_pkg::LDQ_DEPTH - int'(m.tail - m.head);
endfunction

// next load takes the tail slot
function automatic ldq_model_t model_alloc(ldq_model_t m);
	m.state[model_tag(m.tail)] = ldq_state_pkg::LDQ_WAIT_ADDR;
	m.tail++;
	return m;
endfunction

function automatic ldq_model_t model_execute(ldq_model_t m, lsu_if_pkg::execute_ld_t ex);
	m.state[ex.tag]            = ldq_state_pkg::LDQ_READY;
	m.payload[ex.tag].addr     = ex.addr;
	m.payload[ex.tag].size     = ex.size;
	m.payload[ex.tag].pc       = ex.pc;
	m.payload[ex.tag].dest_prn = ex.prn;
	m.payload[ex.tag].rob_tag  = ex.rob_tag;
	return m;
endfunction

function automatic ldq_model_t model_set(ldq_model_t m, lsu_if_pkg::ldq_tag_t tag,
		ldq_state_pkg::ldq_state_e state);
	m.state[tag] = state;
	return m;
endfunction

function automatic ldq_model_t model_data(ldq_model_t m, lsu_if_pkg::dcache_resp_t resp);
	m.state[resp.tag]        = ldq_state_pkg::LDQ_HAS_DATA;
	m.payload[resp.tag].data = resp.data;
	return m;
endfunction

// lowest entry holding data, -1 when none
function automatic int model_lowest_data(ldq_model_t m);
	for (int i = 0; i < ldq_state_pkg::LDQ_DEPTH; i++) begin
		if (m.state[i] == ldq_state_pkg::LDQ_HAS_DATA) begin
			return i;
		end
	end
	return -1;
endfunction

function automatic lsu_if_pkg::issue_req_t model_issue_expect(ldq_model_t m,
		lsu_if_pkg::ldq_tag_t tag);
	return '{addr: m.payload[tag].addr, size: m.payload[tag].size, tag: tag};
endfunction

function automatic lsu_if_pkg::writeback_t model_wb_expect(ldq_model_t m,
		lsu_if_pkg::ldq_tag_t tag);
	return '{data: m.payload[tag].data, pc: m.payload[tag].pc,
		dest_prn: m.payload[tag].dest_prn, rob_tag: m.payload[tag].rob_tag};
endfunction

// frees the oldest entry
function automatic ldq_model_t model_retire(ldq_model_t m);
	m.state[model_tag(m.head)] = ldq_state_pkg::LDQ_FREE;
	m.head++;
	return m;
endfunction

`endif

// ==== dv/ldq_tb.sv ====
`default_nettype none

module ldq_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import ldq_state_pkg::*;
	import lsu_if_pkg::*;

	`include "ldq_ref_model.svh"

	localparam int DISPATCH_WIDTH = 4;
	localparam int NUM_CYCLES     = 3000;

	logic                      clk;
	logic                      rst_n;
	logic                      pipe_flush;
	logic [DISPATCH_WIDTH-1:0] dispatch_valid;
	logic                      dispatch_ready;
	dispatch_resp_t            dispatch_resp [DISPATCH_WIDTH];
	execute_ld_t               execute_ld;
	issue_req_t                issue_req;
	logic                      issue_valid;
	logic                      issue_ready;
	dcache_resp_t              dcache_resp;
	writeback_t                writeback;
	logic                      writeback_valid;
	logic                      writeback_ready;
	retire_slot_t              retire [DISPATCH_WIDTH];

	integer     seed = 6543;
	ldq_model_t m;
	logic       exp_issue_valid; // issue output is one cycle behind the model
	ldq_tag_t   exp_issue_tag;
	logic       wb_held;
	writeback_t last_wb;
	int         flush_count;
	int         wb_count;

	ldq_top #(
		.DISPATCH_WIDTH(DISPATCH_WIDTH)
	) DUT (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic fail_run();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic compare_tag(string name, ldq_tag_t got, ldq_tag_t exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_issue(issue_req_t got, issue_req_t exp);
		if (got !== exp) begin
			$display("Error: issue_req got %h expected %h", got, exp);
			fail_run();
		end
	endtask

	task automatic compare_wb(string name, writeback_t got, writeback_t exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// random starting point so execute and responses hit entries out of order
	function automatic int find_entry(ldq_state_e st);
		int start;
		int idx;
		start = $unsigned($random(seed)) % LDQ_DEPTH;
		for (int i = 0; i < LDQ_DEPTH; i++) begin
			idx = (start + i) % LDQ_DEPTH;
			if (m.state[idx] == st) begin
				return idx;
			end
		end
		return -1;
	endfunction

	function automatic int first_set(logic [LDQ_DEPTH-1:0] mask);
		for (int i = 0; i < LDQ_DEPTH; i++) begin
			if (mask[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	// outputs seen at this edge against the model, then the model takes the edge's events
	task automatic check_and_update();
		logic [LDQ_DEPTH-1:0] ready_left;
		ldq_tag_t             exp_tag;
		ldq_tag_t             wb_tag;
		int                   below;
		int                   lowest;
		below = 0;
		for (int s = 0; s < DISPATCH_WIDTH; s++) begin
			exp_tag = '0;
			if (dispatch_valid[s]) begin
				exp_tag = model_tag(m.tail + below);
				below++;
			end
			compare_tag($sformatf("dispatch_resp[%0d].tag", s), dispatch_resp[s].tag, exp_tag);
		end
		compare_flag("dispatch_ready", dispatch_ready, model_free(m) >= DISPATCH_WIDTH);

		compare_flag("issue_valid", issue_valid, exp_issue_valid);
		if (issue_valid && issue_ready && m.state[issue_req.tag] != LDQ_READY) begin
			$display("issue of tag %0d accepted while that load was not waiting to issue",
				issue_req.tag);
			fail_run();
		end
		if (issue_valid) begin
			compare_issue(issue_req, model_issue_expect(m, exp_issue_tag));
		end
		for (int i = 0; i < LDQ_DEPTH; i++) begin
			ready_left[i] = m.state[i] == LDQ_READY;
		end
		if (issue_valid && issue_ready) begin
			ready_left[issue_req.tag] = 1'b0;
		end

		lowest = model_lowest_data(m);
		wb_tag = '0;
		compare_flag("writeback_valid", writeback_valid, lowest >= 0);
		if (wb_held) begin
			compare_wb("writeback while stalled", writeback, last_wb);
		end
		if (lowest >= 0) begin
			wb_tag = ldq_tag_t'(lowest);
			compare_wb("writeback", writeback, model_wb_expect(m, wb_tag));
		end
		wb_held = writeback_valid && !writeback_ready && !dcache_resp.valid && !pipe_flush;
		last_wb = writeback;

		if (pipe_flush) begin
			m = model_reset();
			flush_count++;
		end else begin
			for (int s = 0; s < DISPATCH_WIDTH; s++) begin
				if (retire[s].valid) begin
					m = model_retire(m);
				end
			end
			for (int s = 0; s < DISPATCH_WIDTH; s++) begin
				if (dispatch_valid[s]) begin
					m = model_alloc(m);
				end
			end
			if (execute_ld.valid) begin
				m = model_execute(m, execute_ld);
			end
			if (issue_valid && issue_ready) begin
				m = model_set(m, issue_req.tag, LDQ_ISSUED);
			end
			if (dcache_resp.valid) begin
				m = model_data(m, dcache_resp);
			end
			if (lowest >= 0 && writeback_ready) begin
				m = model_set(m, wb_tag, LDQ_DONE);
				wb_count++;
			end
		end

		exp_issue_valid = !pipe_flush && |ready_left;
		if (|ready_left) begin
			exp_issue_tag = ldq_tag_t'(first_set(ready_left));
		end
	endtask

	task automatic drive_inputs(bit draining);
		int pick;
		int done_run;
		int n_ret;
		bit flush;
		flush = !draining && ($unsigned($random(seed)) % 128 == 0);
		pipe_flush      <= flush;
		issue_ready     <= ($random(seed) & 3) != 0;
		writeback_ready <= ($random(seed) & 3) != 0;
		dispatch_valid  <= '0;
		execute_ld      <= '0;
		dcache_resp     <= '0;
		for (int s = 0; s < DISPATCH_WIDTH; s++) begin
			retire[s] <= '0;
		end
		if (!flush) begin
			if (!draining && model_free(m) >= DISPATCH_WIDTH) begin
				dispatch_valid <= DISPATCH_WIDTH'($random(seed));
			end
			pick = find_entry(LDQ_WAIT_ADDR);
			if (pick >= 0 && ($random(seed) & 3) != 0) begin
				execute_ld <= '{
					valid:   1'b1,
					tag:     ldq_tag_t'(pick),
					addr:    $random(seed),
					size:    3'($random(seed)),
					pc:      $random(seed),
					prn:     PRF_W'($random(seed)),
					rob_tag: ROB_W'($random(seed))
				};
			end
			pick = find_entry(LDQ_ISSUED);
			if (pick >= 0 && ($random(seed) & 1) != 0) begin
				dcache_resp <= '{valid: 1'b1, tag: ldq_tag_t'(pick), data: $random(seed)};
			end
			// only a run of finished loads at the head may retire
			done_run = 0;
			while (done_run < DISPATCH_WIDTH && m.head + done_run < m.tail
					&& m.state[model_tag(m.head + done_run)] == LDQ_DONE) begin
				done_run++;
			end
			n_ret = $unsigned($random(seed)) % (done_run + 1);
			for (int s = 0; s < n_ret; s++) begin
				retire[s] <= '{valid: 1'b1, tag: model_tag(m.head + s)};
			end
		end
	endtask

	initial begin
		rst_n           = 1'b0;
		pipe_flush      = 1'b0;
		dispatch_valid  = '0;
		execute_ld      = '0;
		issue_ready     = 1'b0;
		dcache_resp     = '0;
		writeback_ready = 1'b0;
		for (int s = 0; s < DISPATCH_WIDTH; s++) begin
			retire[s] = '0;
		end
		m               = model_reset();
		exp_issue_valid = 1'b0;
		exp_issue_tag   = '0;
		wb_held         = 1'b0;
		last_wb         = '0;
		flush_count     = 0;
		wb_count        = 0;

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		for (int c = 0; c < NUM_CYCLES; c++) begin
			@(posedge clk);
			check_and_update();
			drive_inputs(1'b0);
		end
		// no new loads, let everything in flight finish and retire
		while (m.head != m.tail) begin
			@(posedge clk);
			check_and_update();
			drive_inputs(1'b1);
		end

		if (flush_count == 0 || wb_count == 0) begin
			$display("run ended without a flush or without any writeback");
			fail_run();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

	initial begin
		#(NUM_CYCLES * 4 * 100);
		$display("watchdog expired, the queue did not drain in time");
		fail_run();
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/ldq_state_pkg.sv
design/lsu_if_pkg.sv
design/ldq_alloc.sv
design/ldq_entry_array.sv
design/ldq_issue_select.sv
design/ldq_writeback_select.sv
design/ldq_top.sv
dv/ldq_tb.sv

// ==== Makefile ====
# Verilator flow for the load queue
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal --top-module ldq_tb -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ldq_tb -f files.f -o ldq_sim
	./obj_dir/ldq_sim | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
